//--- src/xbar_pkg.sv
`default_nettype none

package xbar_pkg;

	// Read address beat.
	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  size;  // Log2 of the byte count.
	} bus_ar_t;

	typedef enum logic {
		src_ifu,
		src_lsu
	} source_e;

	typedef struct packed {
		bus_ar_t ar;
		source_e source;  // Who gets the response.
	} read_req_t;

	typedef struct packed {
		logic [63:0] data;
		logic [1:0]  resp;
	} read_rsp_t;

	// Timer block answers with a single word.
	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} clint_rsp_t;

	localparam logic [1:0] resp_okay   = 2'd0;
	localparam logic [1:0] resp_slverr = 2'd2;
	localparam logic [1:0] resp_decerr = 2'd3;

endpackage

`default_nettype wire

//--- src/read_arbiter.sv
`default_nettype none

module read_arbiter (
	input  wire logic                  clock,
	input  wire logic                  reset,

	input  wire xbar_pkg::bus_ar_t     ifu_ar,
	input  wire logic                  ifu_arvalid,
	output logic                       ifu_arready,
	output xbar_pkg::read_rsp_t        ifu_r,
	output logic                       ifu_rvalid,
	input  wire logic                  ifu_rready,

	input  wire xbar_pkg::bus_ar_t     lsu_ar,
	input  wire logic                  lsu_arvalid,
	output logic                       lsu_arready,
	output xbar_pkg::read_rsp_t        lsu_r,
	output logic                       lsu_rvalid,
	input  wire logic                  lsu_rready,

	output xbar_pkg::read_req_t        req,
	output logic                       req_valid,
	input  wire logic                  req_ready,

	input  wire xbar_pkg::read_rsp_t   rsp,
	input  wire logic                  rsp_valid,
	output logic                       rsp_ready
);

	typedef enum logic [1:0] {
		st_idle,
		st_issue,
		st_wait
	} state_e;

	state_e state;
	logic ifu_take;
	logic lsu_take;
	logic ret_valid;
	logic ret_ready;
	xbar_pkg::read_rsp_t ret_rsp;

	assign ifu_arready = (state == st_idle);
	assign lsu_arready = (state == st_idle) && !ifu_arvalid;  // Fetch goes first.
	assign ifu_take    = ifu_arvalid && ifu_arready;
	assign lsu_take    = lsu_arvalid && lsu_arready;

	assign req_valid = (state == st_issue);
	assign rsp_ready = (state == st_wait) && !ret_valid;

	// Response goes back to whoever issued the request.
	assign ifu_r      = ret_rsp;
	assign lsu_r      = ret_rsp;
	assign ifu_rvalid = ret_valid && (req.source == xbar_pkg::src_ifu);
	assign lsu_rvalid = ret_valid && (req.source == xbar_pkg::src_lsu);
	assign ret_ready  = (req.source == xbar_pkg::src_ifu) ? ifu_rready : lsu_rready;

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= st_idle;
			ret_valid <= 1'b0;
		end else begin
			case (state)
				st_idle:  if (ifu_take || lsu_take) state <= st_issue;
				st_issue: if (req_ready) state <= st_wait;
				st_wait:  if (ret_valid && ret_ready) state <= st_idle;
				default:  state <= st_idle;
			endcase
			if (rsp_valid && rsp_ready)
				ret_valid <= 1'b1;
			else if (ret_valid && ret_ready)
				ret_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ifu_take) begin
			req.ar     <= ifu_ar;
			req.source <= xbar_pkg::src_ifu;
		end else if (lsu_take) begin
			req.ar     <= lsu_ar;
			req.source <= xbar_pkg::src_lsu;
		end
		if (rsp_valid && rsp_ready) ret_rsp <= rsp;
	end

	assert property (@(posedge clock) disable iff (reset)
		req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

`default_nettype wire

//--- src/fetch_cache.sv
`default_nettype none

module fetch_cache #(
	parameter int fetch_lines = 16
) (
	input  wire logic                  clock,
	input  wire logic                  reset,

	input  wire xbar_pkg::read_req_t   up_req,
	input  wire logic                  up_req_valid,
	output logic                       up_req_ready,

	output xbar_pkg::read_rsp_t        up_rsp,
	output logic                       up_rsp_valid,
	input  wire logic                  up_rsp_ready,

	output xbar_pkg::read_req_t        dn_req,
	output logic                       dn_req_valid,
	input  wire logic                  dn_req_ready,

	input  wire xbar_pkg::read_rsp_t   dn_rsp,
	input  wire logic                  dn_rsp_valid,
	output logic                       dn_rsp_ready
);

	localparam int index_w = $clog2(fetch_lines);
	localparam int tag_w   = 29 - index_w;  // Bits above index and byte offset.

	typedef enum logic [1:0] {
		st_idle,
		st_issue,
		st_wait,
		st_reply
	} state_e;

	state_e state;
	logic [fetch_lines-1:0] line_valid;
	logic [tag_w-1:0]       line_tag [fetch_lines];
	logic [63:0]            line_data [fetch_lines];

	logic [index_w-1:0] up_index;
	logic [tag_w-1:0]   up_tag;
	logic [index_w-1:0] fill_index;
	logic               up_fetch;
	logic               up_hit;
	logic               dn_done;
	logic               fill;

	assign up_index = up_req.ar.addr[3 +: index_w];
	assign up_tag   = up_req.ar.addr[31 -: tag_w];
	assign up_fetch = (up_req.source == xbar_pkg::src_ifu);
	assign up_hit   = up_fetch && line_valid[up_index] && (line_tag[up_index] == up_tag);

	assign dn_done    = dn_rsp_valid && dn_rsp_ready;
	assign fill_index = dn_req.ar.addr[3 +: index_w];
	assign fill       = dn_done && (dn_req.source == xbar_pkg::src_ifu) &&
		(dn_rsp.resp == xbar_pkg::resp_okay);

	assign up_req_ready = (state == st_idle);
	assign up_rsp_valid = (state == st_reply);
	assign dn_req_valid = (state == st_issue);
	assign dn_rsp_ready = (state == st_wait);

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= st_idle;
			line_valid <= '0;
		end else begin
			case (state)
				st_idle:  if (up_req_valid) state <= up_hit ? st_reply : st_issue;
				st_issue: if (dn_req_ready) state <= st_wait;
				st_wait:  if (dn_rsp_valid) state <= st_reply;
				st_reply: if (up_rsp_ready) state <= st_idle;
				default:  state <= st_idle;
			endcase
			if (fill) line_valid[fill_index] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (up_req_valid && up_req_ready) begin
			up_rsp.data <= line_data[up_index];  // Used only on a hit.
			up_rsp.resp <= xbar_pkg::resp_okay;
			dn_req      <= up_req;
			if (up_fetch) begin
				dn_req.ar.addr <= {up_req.ar.addr[31:3], 3'b000};  // Whole beat.
				dn_req.ar.size <= 3'd3;
			end
		end
		if (dn_done) up_rsp <= dn_rsp;
		if (fill) begin
			line_tag[fill_index]  <= dn_req.ar.addr[31 -: tag_w];
			line_data[fill_index] <= dn_rsp.data;
		end
	end

	// An error reply must leave every line as it was.
	assert property (@(posedge clock) disable iff (reset)
		dn_done && dn_rsp.resp != xbar_pkg::resp_okay |=> $stable(line_valid));

endmodule

`default_nettype wire

//--- src/read_router.sv
`default_nettype none

module read_router #(
	parameter logic [31:0] clint_base  = 32'h0200_0000,
	parameter logic [31:0] clint_limit = 32'h0200_ffff
) (
	input  wire logic                  clock,
	input  wire logic                  reset,

	input  wire xbar_pkg::read_req_t   req,
	input  wire logic                  req_valid,
	output logic                       req_ready,

	output xbar_pkg::read_rsp_t        rsp,
	output logic                       rsp_valid,
	input  wire logic                  rsp_ready,

	output xbar_pkg::bus_ar_t          mem_ar,
	output logic                       mem_arvalid,
	input  wire logic                  mem_arready,
	input  wire xbar_pkg::read_rsp_t   mem_r,
	input  wire logic                  mem_rvalid,
	output logic                       mem_rready,

	output xbar_pkg::bus_ar_t          clint_ar,
	output logic                       clint_arvalid,
	input  wire logic                  clint_arready,
	input  wire xbar_pkg::clint_rsp_t  clint_r,
	input  wire logic                  clint_rvalid,
	output logic                       clint_rready
);

	typedef enum logic [1:0] {
		st_idle,
		st_issue,
		st_wait,
		st_reply
	} state_e;

	state_e state;
	xbar_pkg::bus_ar_t ar_q;
	logic to_clint;
	logic in_range;
	logic mem_done;
	logic clint_done;

	assign in_range = (req.ar.addr >= clint_base) && (req.ar.addr <= clint_limit);

	assign req_ready = (state == st_idle);
	assign rsp_valid = (state == st_reply);

	assign mem_ar        = ar_q;
	assign clint_ar      = ar_q;
	assign mem_arvalid   = (state == st_issue) && !to_clint;
	assign clint_arvalid = (state == st_issue) && to_clint;
	assign mem_rready    = (state == st_wait) && !to_clint;
	assign clint_rready  = (state == st_wait) && to_clint;

	assign mem_done   = mem_rvalid && mem_rready;
	assign clint_done = clint_rvalid && clint_rready;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: if (req_valid) state <= st_issue;
				st_issue:
					if ((mem_arvalid && mem_arready) || (clint_arvalid && clint_arready))
						state <= st_wait;
				st_wait: if (mem_done || clint_done) state <= st_reply;
				st_reply: if (rsp_ready) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (req_valid && req_ready) begin
			ar_q     <= req.ar;
			to_clint <= in_range;
		end
		if (mem_done) rsp <= mem_r;
		if (clint_done) begin
			rsp.data <= {32'd0, clint_r.data};  // Zero-extend timer word.
			rsp.resp <= clint_r.resp;
		end
	end

	// Only one downstream target is ever addressed or drained.
	assert property (@(posedge clock) disable iff (reset)
		$onehot0({mem_arvalid, clint_arvalid, mem_rready, clint_rready}));

endmodule

`default_nettype wire

//--- src/xbar_top.sv
`default_nettype none

module xbar_top #(
	parameter int          fetch_lines = 16,
	parameter logic [31:0] clint_base  = 32'h0200_0000,
	parameter logic [31:0] clint_limit = 32'h0200_ffff
) (
	input  wire logic                  clock,
	input  wire logic                  reset,

	input  wire xbar_pkg::bus_ar_t     ifu_ar,
	input  wire logic                  ifu_arvalid,
	output logic                       ifu_arready,
	output xbar_pkg::read_rsp_t        ifu_r,
	output logic                       ifu_rvalid,
	input  wire logic                  ifu_rready,

	input  wire xbar_pkg::bus_ar_t     lsu_ar,
	input  wire logic                  lsu_arvalid,
	output logic                       lsu_arready,
	output xbar_pkg::read_rsp_t        lsu_r,
	output logic                       lsu_rvalid,
	input  wire logic                  lsu_rready,

	output xbar_pkg::bus_ar_t          mem_ar,
	output logic                       mem_arvalid,
	input  wire logic                  mem_arready,
	input  wire xbar_pkg::read_rsp_t   mem_r,
	input  wire logic                  mem_rvalid,
	output logic                       mem_rready,

	output xbar_pkg::bus_ar_t          clint_ar,
	output logic                       clint_arvalid,
	input  wire logic                  clint_arready,
	input  wire xbar_pkg::clint_rsp_t  clint_r,
	input  wire logic                  clint_rvalid,
	output logic                       clint_rready
);

	xbar_pkg::read_req_t arb_req;
	logic                arb_req_valid;
	logic                arb_req_ready;
	xbar_pkg::read_rsp_t arb_rsp;
	logic                arb_rsp_valid;
	logic                arb_rsp_ready;

	xbar_pkg::read_req_t rt_req;  // Cache to router.
	logic                rt_req_valid;
	logic                rt_req_ready;
	xbar_pkg::read_rsp_t rt_rsp;
	logic                rt_rsp_valid;
	logic                rt_rsp_ready;

	read_arbiter i_read_arbiter (
		.clock       (clock),
		.reset       (reset),
		.ifu_ar      (ifu_ar),
		.ifu_arvalid (ifu_arvalid),
		.ifu_arready (ifu_arready),
		.ifu_r       (ifu_r),
		.ifu_rvalid  (ifu_rvalid),
		.ifu_rready  (ifu_rready),
		.lsu_ar      (lsu_ar),
		.lsu_arvalid (lsu_arvalid),
		.lsu_arready (lsu_arready),
		.lsu_r       (lsu_r),
		.lsu_rvalid  (lsu_rvalid),
		.lsu_rready  (lsu_rready),
		.req         (arb_req),
		.req_valid   (arb_req_valid),
		.req_ready   (arb_req_ready),
		.rsp         (arb_rsp),
		.rsp_valid   (arb_rsp_valid),
		.rsp_ready   (arb_rsp_ready)
	);

	fetch_cache #(
		.fetch_lines (fetch_lines)
	) i_fetch_cache (
		.clock        (clock),
		.reset        (reset),
		.up_req       (arb_req),
		.up_req_valid (arb_req_valid),
		.up_req_ready (arb_req_ready),
		.up_rsp       (arb_rsp),
		.up_rsp_valid (arb_rsp_valid),
		.up_rsp_ready (arb_rsp_ready),
		.dn_req       (rt_req),
		.dn_req_valid (rt_req_valid),
		.dn_req_ready (rt_req_ready),
		.dn_rsp       (rt_rsp),
		.dn_rsp_valid (rt_rsp_valid),
		.dn_rsp_ready (rt_rsp_ready)
	);

	read_router #(
		.clint_base  (clint_base),
		.clint_limit (clint_limit)
	) i_read_router (
		.clock         (clock),
		.reset         (reset),
		.req           (rt_req),
		.req_valid     (rt_req_valid),
		.req_ready     (rt_req_ready),
		.rsp           (rt_rsp),
		.rsp_valid     (rt_rsp_valid),
		.rsp_ready     (rt_rsp_ready),
		.mem_ar        (mem_ar),
		.mem_arvalid   (mem_arvalid),
		.mem_arready   (mem_arready),
		.mem_r         (mem_r),
		.mem_rvalid    (mem_rvalid),
		.mem_rready    (mem_rready),
		.clint_ar      (clint_ar),
		.clint_arvalid (clint_arvalid),
		.clint_arready (clint_arready),
		.clint_r       (clint_r),
		.clint_rvalid  (clint_rvalid),
		.clint_rready  (clint_rready)
	);

endmodule

`default_nettype wire

//--- bench/xbar_tb.sv
`default_nettype none

module xbar_tb;

	localparam int          fetch_lines = 16;
	localparam int          index_w     = $clog2(fetch_lines);
	localparam logic [31:0] clint_base  = 32'h0200_0000;
	localparam logic [31:0] clint_limit = 32'h0200_ffff;
	localparam int          n_trans     = 400;
	localparam int          max_latency = 200;  // Cycles, with back-pressure.

	logic clock = 1'b0;
	logic reset = 1'b1;

	xbar_pkg::bus_ar_t    ifu_ar = '0;
	logic                 ifu_arvalid = 1'b0;
	logic                 ifu_arready;
	xbar_pkg::read_rsp_t  ifu_r;
	logic                 ifu_rvalid;
	logic                 ifu_rready = 1'b0;
	xbar_pkg::bus_ar_t    lsu_ar = '0;
	logic                 lsu_arvalid = 1'b0;
	logic                 lsu_arready;
	xbar_pkg::read_rsp_t  lsu_r;
	logic                 lsu_rvalid;
	logic                 lsu_rready = 1'b0;
	xbar_pkg::bus_ar_t    mem_ar;
	logic                 mem_arvalid;
	logic                 mem_arready = 1'b0;
	xbar_pkg::read_rsp_t  mem_r = '0;
	logic                 mem_rvalid = 1'b0;
	logic                 mem_rready;
	xbar_pkg::bus_ar_t    clint_ar;
	logic                 clint_arvalid;
	logic                 clint_arready = 1'b0;
	xbar_pkg::clint_rsp_t clint_r = '0;
	logic                 clint_rvalid = 1'b0;
	logic                 clint_rready;

	logic [31:0] mem_addr;
	logic        mem_pending;
	int          mem_delay;
	logic [31:0] clint_addr;
	logic        clint_pending;
	int          clint_delay;

	logic [fetch_lines-1:0] m_valid;  // Cache model.
	logic [28:0]            m_line [fetch_lines];
	logic [63:0]            m_data [fetch_lines];

	logic                busy;
	logic                exp_dn;
	logic                exp_clint;
	logic                rvalid_seen;
	xbar_pkg::source_e   exp_src;
	xbar_pkg::bus_ar_t   exp_ar;
	xbar_pkg::read_rsp_t exp_rsp;
	logic                mem_held;
	logic                clint_held;
	logic                ifu_held;
	logic                lsu_held;
	xbar_pkg::bus_ar_t   mem_prev;
	xbar_pkg::bus_ar_t   clint_prev;
	xbar_pkg::read_rsp_t ifu_prev;
	xbar_pkg::read_rsp_t lsu_prev;
	int started;
	int done_count;
	int dn_beats;
	int cycle;
	int accept_cycle;
	int n_hit;
	int n_miss;
	int n_evict;
	int n_err;
	int n_clint;
	int n_load_cached;
	int n_both;

	xbar_top #(
		.fetch_lines (fetch_lines),
		.clint_base  (clint_base),
		.clint_limit (clint_limit)
	) i_xbar_top (.*);

	always #50 clock = ~clock;

	task automatic report_mismatch(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("** Error [%s]: expected %h, actual %h", name, expected, actual);
		$display("Test failures found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_failure(input string what);
		$display("** Error: %s", what);
		$display("Test failures found");
		$fatal(1, "stopped at the first error");
	endtask

	// Four tags over eight lines, so fetches hit and evict.
	function automatic xbar_pkg::bus_ar_t pick_fetch();
		xbar_pkg::bus_ar_t ar;
		ar.addr = 32'h8000_0000 | ($urandom_range(3) << (3 + index_w)) |
			($urandom_range(7) << 3) | $urandom_range(7);
		ar.size = 3'($urandom_range(3));
		return ar;
	endfunction

	function automatic xbar_pkg::bus_ar_t pick_load();
		xbar_pkg::bus_ar_t ar;
		int kind;
		kind = $urandom_range(7);
		ar = pick_fetch();
		if (kind < 3)
			ar.addr = clint_base + $urandom_range(32'h0000_ffff);
		else if (kind == 7)
			ar.addr = ($urandom_range(1) == 0) ? clint_limit + 32'd1 : clint_base - 32'd1;
		return ar;
	endfunction

	function automatic logic [63:0] mem_data(input logic [31:0] addr);
		logic [31:0] line;
		line = {addr[31:3], 3'b000};
		return {line ^ 32'h5ee0_c0de, ~line};
	endfunction

	function automatic logic [1:0] mem_resp(input logic [31:0] addr);
		return (addr[5:3] == 3'b111) ? xbar_pkg::resp_slverr : xbar_pkg::resp_okay;
	endfunction

	function automatic logic [31:0] clint_data(input logic [31:0] addr);
		return addr ^ 32'h7e11_d00d;
	endfunction

	function automatic logic in_clint(input logic [31:0] addr);
		return (addr >= clint_base) && (addr <= clint_limit);
	endfunction

	task automatic accept_request();
		xbar_pkg::bus_ar_t  ar;
		logic [index_w-1:0] idx;
		logic               cached;
		assert (!busy) else report_failure("a request was accepted while another was in flight");
		assert (!(lsu_arvalid && lsu_arready && ifu_arvalid))
			else report_failure("a load was accepted ahead of a waiting fetch");
		if (ifu_arvalid && lsu_arvalid) n_both++;
		exp_src = (ifu_arvalid && ifu_arready) ? xbar_pkg::src_ifu : xbar_pkg::src_lsu;
		ar = (exp_src == xbar_pkg::src_ifu) ? ifu_ar : lsu_ar;
		idx = ar.addr[3 +: index_w];
		cached = m_valid[idx] && (m_line[idx] == ar.addr[31:3]);
		busy = 1'b1;
		rvalid_seen = 1'b0;
		dn_beats = 0;
		accept_cycle = cycle;
		exp_dn = !(exp_src == xbar_pkg::src_ifu && cached);
		exp_ar = ar;
		if (exp_src == xbar_pkg::src_ifu) begin
			exp_ar.addr = {ar.addr[31:3], 3'b000};  // Whole beat.
			exp_ar.size = 3'd3;
		end
		exp_clint = in_clint(exp_ar.addr);
		if (!exp_dn) begin
			exp_rsp.data = m_data[idx];
			exp_rsp.resp = xbar_pkg::resp_okay;
			n_hit++;
		end else if (exp_clint) begin
			exp_rsp.data = {32'd0, clint_data(exp_ar.addr)};
			exp_rsp.resp = xbar_pkg::resp_okay;
		end else begin
			exp_rsp.data = mem_data(exp_ar.addr);
			exp_rsp.resp = mem_resp(exp_ar.addr);
		end
		if (exp_src == xbar_pkg::src_lsu) begin
			if (exp_clint) n_clint++;
			if (cached) n_load_cached++;
		end else if (exp_dn && exp_rsp.resp != xbar_pkg::resp_okay) begin
			n_err++;  // No fill.
		end else if (exp_dn) begin
			if (m_valid[idx]) n_evict++;
			m_valid[idx] = 1'b1;
			m_line[idx]  = ar.addr[31:3];
			m_data[idx]  = exp_rsp.data;
			n_miss++;
		end
	endtask

	task automatic finish_response(input xbar_pkg::source_e src, input xbar_pkg::read_rsp_t r,
			input string port);
		assert (busy && exp_src == src)
			else report_failure({"a response on ", port, " had no matching request"});
		assert (dn_beats == (exp_dn ? 1 : 0))
			else report_mismatch({port, " downstream beats"}, 64'(exp_dn), 64'(dn_beats));
		assert (r.data == exp_rsp.data) else report_mismatch({port, ".data"}, exp_rsp.data, r.data);
		assert (r.resp == exp_rsp.resp)
			else report_mismatch({port, ".resp"}, 64'(exp_rsp.resp), 64'(r.resp));
		busy = 1'b0;
		done_count++;
	endtask

	// Requesters with random valid timing and response back-pressure.
	always @(posedge clock) begin
		if (reset) begin
			ifu_arvalid <= 1'b0;
			lsu_arvalid <= 1'b0;
			ifu_rready  <= 1'b0;
			lsu_rready  <= 1'b0;
			started = 0;
		end else begin
			ifu_rready <= ($urandom_range(3) != 0);
			lsu_rready <= ($urandom_range(3) != 0);
			if (ifu_arvalid && ifu_arready) begin
				ifu_arvalid <= 1'b0;
			end else if (!ifu_arvalid && started < n_trans && $urandom_range(2) == 0) begin
				ifu_ar      <= pick_fetch();
				ifu_arvalid <= 1'b1;
				started++;
			end
			if (lsu_arvalid && lsu_arready) begin
				lsu_arvalid <= 1'b0;
			end else if (!lsu_arvalid && started < n_trans && $urandom_range(2) == 0) begin
				lsu_ar      <= pick_load();
				lsu_arvalid <= 1'b1;
				started++;
			end
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			mem_arready <= 1'b0;
			mem_rvalid  <= 1'b0;
			mem_pending <= 1'b0;
		end else begin
			mem_arready <= ($urandom_range(2) != 0);
			if (mem_arvalid && mem_arready) begin
				mem_addr    <= mem_ar.addr;
				mem_delay   <= $urandom_range(5);
				mem_pending <= 1'b1;
			end
			if (mem_pending && mem_delay > 0) begin
				mem_delay <= mem_delay - 1;
			end else if (mem_pending) begin
				mem_r.data  <= mem_data(mem_addr);
				mem_r.resp  <= mem_resp(mem_addr);
				mem_rvalid  <= 1'b1;
				mem_pending <= 1'b0;
			end
			if (mem_rvalid && mem_rready)
				mem_rvalid <= 1'b0;
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			clint_arready <= 1'b0;
			clint_rvalid  <= 1'b0;
			clint_pending <= 1'b0;
		end else begin
			clint_arready <= ($urandom_range(2) != 0);
			if (clint_arvalid && clint_arready) begin
				clint_addr    <= clint_ar.addr;
				clint_delay   <= $urandom_range(3);
				clint_pending <= 1'b1;
			end
			if (clint_pending && clint_delay > 0) begin
				clint_delay <= clint_delay - 1;
			end else if (clint_pending) begin
				clint_r.data  <= clint_data(clint_addr);
				clint_r.resp  <= xbar_pkg::resp_okay;
				clint_rvalid  <= 1'b1;
				clint_pending <= 1'b0;
			end
			if (clint_rvalid && clint_rready)
				clint_rvalid <= 1'b0;
		end
	end

	// Scoreboard samples values from before the edge.
	always @(posedge clock) begin
		if (reset) begin
			busy       = 1'b0;
			m_valid    = '0;
			mem_held   = 1'b0;
			clint_held = 1'b0;
			ifu_held   = 1'b0;
			lsu_held   = 1'b0;
		end else begin
			cycle++;
			assert (!mem_held || (mem_arvalid && mem_ar == mem_prev))
				else report_failure("mem_ar changed or dropped while stalled");
			assert (!clint_held || (clint_arvalid && clint_ar == clint_prev))
				else report_failure("clint_ar changed or dropped while stalled");
			assert (!ifu_held || (ifu_rvalid && ifu_r == ifu_prev))
				else report_failure("ifu_r changed or dropped while stalled");
			assert (!lsu_held || (lsu_rvalid && lsu_r == lsu_prev))
				else report_failure("lsu_r changed or dropped while stalled");
			assert (!(ifu_rvalid && lsu_rvalid)) else report_failure("both response ports were valid");
			if (mem_arvalid && mem_arready) begin
				assert (busy && exp_dn && !exp_clint && dn_beats == 0)
					else report_failure("an unexpected beat appeared on mem_ar");
				assert (mem_ar == exp_ar)
					else report_mismatch("mem_ar", {29'd0, exp_ar}, {29'd0, mem_ar});
				dn_beats++;
			end
			if (clint_arvalid && clint_arready) begin
				assert (busy && exp_dn && exp_clint && dn_beats == 0)
					else report_failure("an unexpected beat appeared on clint_ar");
				assert (clint_ar == exp_ar)
					else report_mismatch("clint_ar", {29'd0, exp_ar}, {29'd0, clint_ar});
				dn_beats++;
			end
			assert (!mem_rready || (busy && exp_dn && !exp_clint && dn_beats == 1))
				else report_failure("mem_rready was high with no memory read outstanding");
			assert (!clint_rready || (busy && exp_dn && exp_clint && dn_beats == 1))
				else report_failure("clint_rready was high with no timer read outstanding");
			if (busy && !exp_dn && !rvalid_seen && (ifu_rvalid || lsu_rvalid)) begin
				assert (cycle == accept_cycle + 3)
					else report_mismatch("hit latency", 64'(accept_cycle + 3), 64'(cycle));
				rvalid_seen = 1'b1;
			end
			if (ifu_rvalid && ifu_rready) finish_response(xbar_pkg::src_ifu, ifu_r, "ifu_r");
			if (lsu_rvalid && lsu_rready) finish_response(xbar_pkg::src_lsu, lsu_r, "lsu_r");
			if ((ifu_arvalid && ifu_arready) || (lsu_arvalid && lsu_arready))
				accept_request();
			mem_held   = mem_arvalid && !mem_arready;
			clint_held = clint_arvalid && !clint_arready;
			ifu_held   = ifu_rvalid && !ifu_rready;
			lsu_held   = lsu_rvalid && !lsu_rready;
			mem_prev   = mem_ar;
			clint_prev = clint_ar;
			ifu_prev   = ifu_r;
			lsu_prev   = lsu_r;
		end
	end

	initial begin
		#((n_trans * max_latency + 100) * 100);
		report_failure("watchdog expired before all transactions finished");
	end

	initial begin
		void'($urandom(32'ha7c6_17c0));
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		assert (ifu_arready && lsu_arready && !ifu_rvalid && !lsu_rvalid &&
			!mem_arvalid && !clint_arvalid)
			else report_failure("ports were not idle after reset");
		wait (done_count == n_trans);
		repeat (4) @(posedge clock);
		assert (n_hit > 0 && n_miss > 0 && n_evict > 0 && n_err > 0 && n_clint > 0 &&
			n_load_cached > 0 && n_both > 0)
			else report_failure("random stimulus did not reach every case");
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
src/xbar_pkg.sv
src/read_arbiter.sv
src/fetch_cache.sv
src/read_router.sv
src/xbar_top.sv
bench/xbar_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module xbar_tb -Mdir obj_dir -f src.f
	@out="$$(./obj_dir/Vxbar_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf obj_dir
